/* vlog.f */
vx_pkg.sv
vx_front_end.sv
vx_scheduler.sv
vx_back_end.sv
vx_mem_controller.sv
vortex.sv
vortex_sva.sv
vortex_tb.sv

/* vortex.sv */
`timescale 1ns/1ps
`default_nettype none

module vortex import vx_pkg::*; (
	input  logic            clk,
	input  logic            rst_n,
	input  imem_wr_t        imem_wr,
	output logic            io_valid,
	output logic [xlen-1:0] io_data,
	output logic            out_ebreak
);

	logic            schedule_delay;
	fetch_t          fetch;
	issue_t          issue;
	redirect_t       redirect;
	wb_t             wb;
	dmem_req_t       dmem_req;
	dmem_req_t       dmem_req_qual;
	logic [xlen-1:0] imem_addr;
	instr_u          imem_data;
	logic [xlen-1:0] dmem_rdata;

	// IO bus store intercept
	assign io_valid = dmem_req.valid && dmem_req.write && dmem_req.addr == io_bus_addr;
	assign io_data  = dmem_req.wdata;

	// IO stores never reach data memory
	always_comb begin
		dmem_req_qual       = dmem_req;
		dmem_req_qual.valid = dmem_req.valid && !io_valid;
	end

	vx_front_end front_end (
		.clk            (clk),
		.rst_n          (rst_n),
		.schedule_delay (schedule_delay),
		.redirect       (redirect),
		.imem_addr      (imem_addr),
		.imem_data      (imem_data),
		.fetch          (fetch),
		.out_ebreak     (out_ebreak)
	);

	vx_scheduler schedule (
		.clk            (clk),
		.rst_n          (rst_n),
		.fetch          (fetch),
		.redirect       (redirect),
		.wb             (wb),
		.issue          (issue),
		.schedule_delay (schedule_delay)
	);

	vx_back_end back_end (
		.clk        (clk),
		.rst_n      (rst_n),
		.issue      (issue),
		.redirect   (redirect),
		.dmem_req   (dmem_req),
		.dmem_rdata (dmem_rdata),
		.wb         (wb)
	);

	vx_mem_controller mem_controller (
		.clk        (clk),
		.imem_wr    (imem_wr),
		.imem_addr  (imem_addr),
		.imem_data  (imem_data),
		.dmem_req   (dmem_req_qual),
		.dmem_rdata (dmem_rdata)
	);

endmodule

`default_nettype wire

/* vortex_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module vortex_sva import vx_pkg::*; (
	input logic      clk,
	input logic      rst_n,
	input logic      io_valid,
	input logic      out_ebreak,
	input dmem_req_t dmem_req
);

	int fails = 0;

	// Second reset cycle onward, so the flops have been cleared
	quiet_in_reset: assert property (@(posedge clk)
		(!rst_n ##1 !rst_n) |-> (!io_valid && !out_ebreak))
	else begin
		fails++;
		$error("io_valid or out_ebreak high during reset");
	end

	ebreak_sticky: assert property (@(posedge clk)
		(rst_n ##1 rst_n) |-> !$fell(out_ebreak))
	else begin
		fails++;
		$error("out_ebreak fell without a reset");
	end

	// An IO store must be kept away from data memory
	io_not_dmem: assert property (@(posedge clk) disable iff (!rst_n)
		io_valid |-> !(dmem_req.valid && dmem_req.write))
	else begin
		fails++;
		$error("data memory write in the same cycle as io_valid");
	end

endmodule

bind vortex vortex_sva sva0 (
	.clk        (clk),
	.rst_n      (rst_n),
	.io_valid   (io_valid),
	.out_ebreak (out_ebreak),
	.dmem_req   (dmem_req_qual)
);

`default_nettype wire

/* vortex_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module vortex_tb import vx_pkg::*; ();

	localparam int clk_period = 10;
	localparam int reset_cycles = 16;
	localparam int drain_cycles = 8;
	localparam int ebreak_limit = 150;
	localparam int test_cycles = 200;
	localparam int n_tests = 5;

	logic            clk = 1'b0;
	logic            rst_n;
	imem_wr_t        imem_wr;
	logic            io_valid;
	logic [xlen-1:0] io_data;
	logic            out_ebreak;

	logic [31:0] prog[$];
	logic [31:0] expected[$];
	logic [31:0] seen[$];
	int          errors;
	int          checks;

	vortex dut0 (
		.clk        (clk),
		.rst_n      (rst_n),
		.imem_wr    (imem_wr),
		.io_valid   (io_valid),
		.io_data    (io_data),
		.out_ebreak (out_ebreak)
	);

	always #(clk_period / 2) clk = ~clk;

	function automatic logic [31:0] enc_r(input logic [3:0] op, input logic [3:0] rd,
			input logic [3:0] rs1, input logic [3:0] rs2);
		return {op, rd, rs1, rs2, 16'h0000};
	endfunction

	function automatic logic [31:0] enc_i(input logic [3:0] op, input logic [3:0] rd,
			input logic [3:0] rs1, input logic [19:0] imm);
		return {op, rd, rs1, imm};
	endfunction

	function automatic logic [31:0] store_io(input logic [3:0] rs);
		return enc_i(op_sw, rs, 4'd0, io_bus_addr[19:0]);
	endfunction

	function automatic logic [31:0] sext20(input logic [19:0] v);
		return {{12{v[19]}}, v};
	endfunction

	// Reset with program load, then run until ebreak plus drain
	task automatic load_and_run(input string name);
		int cycles;
		@(negedge clk);
		rst_n = 1'b0;
		for (int i = 0; i < reset_cycles; i++) begin
			imem_wr.en   = 1'b1;
			imem_wr.addr = i[imem_aw-1:0];
			imem_wr.data = (i < prog.size()) ? prog[i] : enc_i(op_ebreak, 4'd0, 4'd0, 20'd0);
			@(negedge clk);
		end
		imem_wr = '0;
		checks++;
		if (out_ebreak) begin
			$display("%s: out_ebreak still high at the end of reset", name);
			errors++;
		end
		rst_n = 1'b1;
		seen.delete();
		cycles = 0;
		while (!out_ebreak && cycles < ebreak_limit) begin
			@(negedge clk);
			if (io_valid) begin
				seen.push_back(io_data);
			end
			cycles++;
		end
		checks++;
		if (!out_ebreak) begin
			$display("%s: out_ebreak did not rise within %0d cycles", name, ebreak_limit);
			errors++;
		end
		for (int i = 0; i < drain_cycles; i++) begin
			@(negedge clk);
			if (io_valid) begin
				seen.push_back(io_data);
			end
			checks++;
			if (!out_ebreak) begin
				$display("%s: out_ebreak dropped while draining at %0t", name, $time);
				errors++;
			end
		end
		checks++;
		if (seen.size() != expected.size()) begin
			$display("%s: expected %0d IO writes, saw %0d", name, expected.size(), seen.size());
			errors++;
		end
		for (int i = 0; i < expected.size() && i < seen.size(); i++) begin
			checks++;
			if (seen[i] !== expected[i]) begin
				$display("[ERROR] %0t io_data (%s, write %0d): expected %h, got %h",
					$time, name, i, expected[i], seen[i]);
				errors++;
			end
		end
	endtask

	task automatic alu_ops();
		logic [19:0] a;
		logic [19:0] b;
		logic [31:0] x;
		logic [31:0] y;
		a = 20'($urandom() & 32'h0fff);
		b = 20'($urandom() & 32'h0fff);
		x = sext20(a);
		y = sext20(b);
		prog.delete();
		expected.delete();
		prog.push_back(enc_i(op_addi, 4'd1, 4'd0, a));
		prog.push_back(enc_i(op_addi, 4'd2, 4'd0, b));
		prog.push_back(enc_r(op_add, 4'd3, 4'd1, 4'd2));
		prog.push_back(store_io(4'd3));
		prog.push_back(enc_r(op_sub, 4'd4, 4'd1, 4'd2));
		prog.push_back(store_io(4'd4));
		prog.push_back(enc_r(op_and, 4'd5, 4'd1, 4'd2));
		prog.push_back(store_io(4'd5));
		prog.push_back(enc_r(op_or, 4'd6, 4'd1, 4'd2));
		prog.push_back(store_io(4'd6));
		prog.push_back(enc_r(op_xor, 4'd7, 4'd1, 4'd2));
		prog.push_back(store_io(4'd7));
		prog.push_back(enc_i(op_ebreak, 4'd0, 4'd0, 20'd0));
		expected.push_back(x + y);
		expected.push_back(x - y);
		expected.push_back(x & y);
		expected.push_back(x | y);
		expected.push_back(x ^ y);
		load_and_run("alu");
	endtask

	// Each ADDI reads the result of the one before
	task automatic dep_chain();
		logic [19:0] k;
		logic [31:0] sum;
		prog.delete();
		expected.delete();
		sum = '0;
		for (int i = 0; i < 8; i++) begin
			k = 20'($urandom());
			sum = sum + sext20(k);
			prog.push_back(enc_i(op_addi, 4'(i + 1), 4'(i), k));
		end
		prog.push_back(store_io(4'd8));
		prog.push_back(enc_i(op_ebreak, 4'd0, 4'd0, 20'd0));
		expected.push_back(sum);
		load_and_run("dep_chain");
	endtask

	task automatic load_store();
		logic [19:0] v [3];
		logic [19:0] addr [3];
		addr[0] = 20'h00010;
		addr[1] = 20'h00024;
		addr[2] = 20'h003fc;
		prog.delete();
		expected.delete();
		for (int i = 0; i < 3; i++) begin
			v[i] = 20'($urandom());
			prog.push_back(enc_i(op_addi, 4'(i + 1), 4'd0, v[i]));
		end
		for (int i = 0; i < 3; i++) begin
			prog.push_back(enc_i(op_sw, 4'(i + 1), 4'd0, addr[i]));
		end
		for (int i = 0; i < 3; i++) begin
			prog.push_back(enc_i(op_lw, 4'(i + 4), 4'd0, addr[i]));
		end
		for (int i = 0; i < 3; i++) begin
			prog.push_back(store_io(4'(i + 4)));
			expected.push_back(sext20(v[i]));
		end
		// r0 written, then used as a source
		prog.push_back(enc_i(op_addi, 4'd0, 4'd0, 20'h005a5));
		prog.push_back(enc_i(op_addi, 4'd7, 4'd0, 20'd3));
		prog.push_back(store_io(4'd7));
		prog.push_back(enc_i(op_ebreak, 4'd0, 4'd0, 20'd0));
		expected.push_back(32'd3);
		load_and_run("memory");
	endtask

	task automatic branch_and_jump();
		logic [19:0] c;
		logic [31:0] jal_pc;
		c = 20'($urandom());
		jal_pc = 9 * 4;
		prog.delete();
		expected.delete();
		prog.push_back(enc_i(op_addi, 4'd1, 4'd0, c));
		prog.push_back(enc_i(op_addi, 4'd2, 4'd0, c));
		// Taken branch over words 3 to 5
		prog.push_back(enc_i(op_beq, 4'd2, 4'd1, 20'd4));
		prog.push_back(store_io(4'd1));
		prog.push_back(store_io(4'd1));
		prog.push_back(store_io(4'd1));
		prog.push_back(enc_i(op_bne, 4'd2, 4'd1, 20'd8));
		prog.push_back(enc_i(op_addi, 4'd3, 4'd0, 20'h00055));
		prog.push_back(store_io(4'd3));
		prog.push_back(enc_i(op_jal, 4'd4, 4'd0, 20'd3));
		prog.push_back(store_io(4'd3));
		prog.push_back(store_io(4'd3));
		prog.push_back(store_io(4'd4));
		prog.push_back(enc_i(op_ebreak, 4'd0, 4'd0, 20'd0));
		expected.push_back(32'h0000_0055);
		expected.push_back(jal_pc + 4);
		load_and_run("control_flow");
	endtask

	task automatic ebreak_halt();
		prog.delete();
		expected.delete();
		prog.push_back(enc_i(op_addi, 4'd1, 4'd0, 20'h0002a));
		prog.push_back(store_io(4'd1));
		prog.push_back(enc_i(op_ebreak, 4'd0, 4'd0, 20'd0));
		prog.push_back(store_io(4'd1));
		prog.push_back(enc_i(op_addi, 4'd2, 4'd0, 20'd1));
		prog.push_back(store_io(4'd2));
		expected.push_back(32'h0000_002a);
		load_and_run("ebreak");
		for (int i = 0; i < 16; i++) begin
			@(negedge clk);
			checks++;
			if (!out_ebreak || io_valid) begin
				$display("ebreak: core left the stopped state at %0t", $time);
				errors++;
			end
		end
		@(negedge clk);
		rst_n = 1'b0;
		@(negedge clk);
		@(negedge clk);
		checks++;
		if (out_ebreak) begin
			$display("ebreak: out_ebreak not cleared by reset");
			errors++;
		end
	endtask

	initial begin
		rst_n   = 1'b0;
		imem_wr = '0;
		errors  = 0;
		checks  = 0;
		void'($urandom(96));
		alu_ops();
		dep_chain();
		load_store();
		branch_and_jump();
		ebreak_halt();
		errors = errors + dut0.sva0.fails;
		$display("checks: %0d, errors: %0d, assertion failures: %0d",
			checks, errors, dut0.sva0.fails);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

	initial begin
		#(n_tests * test_cycles * clk_period);
		$display("Watchdog: run did not finish within %0d cycles", n_tests * test_cycles);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* vx_back_end.sv */
`timescale 1ns/1ps
`default_nettype none

module vx_back_end import vx_pkg::*; (
	input  logic            clk,
	input  logic            rst_n,
	input  issue_t          issue,
	output redirect_t       redirect,
	output dmem_req_t       dmem_req,
	input  logic [xlen-1:0] dmem_rdata,
	output wb_t             wb
);

	logic [xlen-1:0] regs [nregs];

	logic            ex_valid;
	logic [xlen-1:0] ex_pc;
	instr_u          ex_instr;
	logic [xlen-1:0] ex_a;
	logic [xlen-1:0] ex_b;
	logic [3:0]      ex_op;
	logic [xlen-1:0] ex_imm;
	logic [xlen-1:0] ex_result;
	logic [xlen-1:0] ex_target;
	logic            ex_taken;
	logic            ex_go;

	logic            mem_valid;
	logic [3:0]      mem_op;
	logic [3:0]      mem_rd;
	logic [xlen-1:0] mem_result;
	logic [xlen-1:0] mem_wdata;

	logic            wb_valid;
	logic            wb_load;
	logic [3:0]      wb_rd;
	logic [xlen-1:0] wb_data;

	// Operand read with r0 forced to zero
	always_ff @(posedge clk) begin
		ex_pc    <= issue.pc;
		ex_instr <= issue.instr;
		ex_a     <= (issue.rs1 == '0) ? '0 : regs[issue.rs1];
		ex_b     <= (issue.rs2 == '0) ? '0 : regs[issue.rs2];
		if (!rst_n) begin
			ex_valid <= 1'b0;
		end else begin
			ex_valid <= issue.valid;
		end
	end

	assign ex_op     = ex_instr.r.opcode;
	assign ex_imm    = {{(xlen - 20){ex_instr.i.imm[19]}}, ex_instr.i.imm};
	assign ex_target = ex_pc + {ex_imm[xlen-3:0], 2'b00};

	// Whatever sits in execute during a redirect is on the wrong path
	assign ex_go = ex_valid && !redirect.valid;

	always_comb begin
		case (ex_op)
			op_add: ex_result = ex_a + ex_b;
			op_sub: ex_result = ex_a - ex_b;
			op_and: ex_result = ex_a & ex_b;
			op_or: ex_result = ex_a | ex_b;
			op_xor: ex_result = ex_a ^ ex_b;
			op_addi, op_lw, op_sw: ex_result = ex_a + ex_imm;
			op_jal: ex_result = ex_pc + 4;
			default: ex_result = '0;
		endcase
	end

	always_comb begin
		case (ex_op)
			op_beq: ex_taken = ex_a == ex_b;
			op_bne: ex_taken = ex_a != ex_b;
			op_jal: ex_taken = 1'b1;
			default: ex_taken = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		redirect.target <= ex_target;
		if (!rst_n) begin
			redirect.valid <= 1'b0;
		end else begin
			redirect.valid <= ex_go && ex_taken;
		end
	end

	always_ff @(posedge clk) begin
		mem_op     <= ex_op;
		mem_rd     <= ex_instr.i.rd;
		mem_result <= ex_result;
		mem_wdata  <= ex_b;
		if (!rst_n) begin
			mem_valid <= 1'b0;
		end else begin
			mem_valid <= ex_go;
		end
	end

	always_comb begin
		dmem_req.valid = mem_valid && (mem_op == op_lw || mem_op == op_sw);
		dmem_req.write = mem_op == op_sw;
		dmem_req.addr  = mem_result;
		dmem_req.wdata = mem_wdata;
	end

	always_ff @(posedge clk) begin
		wb_rd   <= mem_rd;
		wb_load <= mem_op == op_lw;
		wb_data <= mem_result;
		if (!rst_n) begin
			wb_valid <= 1'b0;
		end else begin
			wb_valid <= mem_valid && writes_rd(mem_op);
		end
	end

	// Load data arrives with the writeback cycle
	always_comb begin
		wb.valid = wb_valid;
		wb.rd    = wb_rd;
		wb.data  = wb_load ? dmem_rdata : wb_data;
	end

	always_ff @(posedge clk) begin
		if (wb.valid && wb.rd != '0) begin
			regs[wb.rd] <= wb.data;
		end
	end

endmodule

`default_nettype wire

/* vx_front_end.sv */
`timescale 1ns/1ps
`default_nettype none

module vx_front_end import vx_pkg::*; (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            schedule_delay,
	input  redirect_t       redirect,
	output logic [xlen-1:0] imem_addr,
	input  instr_u          imem_data,
	output fetch_t          fetch,
	output logic            out_ebreak
);

	// pc is the next request, f_pc the word now on imem_data
	logic [xlen-1:0] pc;
	logic [xlen-1:0] f_pc;
	logic            f_valid;
	logic            ebreak_now;
	logic            stop;

	always_comb begin
		fetch.valid = f_valid && !redirect.valid && !out_ebreak;
		fetch.pc    = f_pc;
		fetch.instr = imem_data;
	end

	assign ebreak_now = fetch.valid && !schedule_delay && imem_data.r.opcode == op_ebreak;
	assign stop       = out_ebreak || ebreak_now;

	// Re-read the held word while stalled so imem_data stays put
	always_comb begin
		if (redirect.valid) begin
			imem_addr = redirect.target;
		end else if (schedule_delay) begin
			imem_addr = f_pc;
		end else begin
			imem_addr = pc;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc      <= '0;
			f_pc    <= '0;
			f_valid <= 1'b0;
		end else if (stop) begin
			f_valid <= 1'b0;
		end else if (redirect.valid) begin
			f_pc    <= redirect.target;
			pc      <= redirect.target + 4;
			f_valid <= 1'b1;
		end else if (!schedule_delay) begin
			f_pc    <= pc;
			pc      <= pc + 4;
			f_valid <= 1'b1;
		end
	end

	// Sticky until the next reset
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out_ebreak <= 1'b0;
		end else if (ebreak_now) begin
			out_ebreak <= 1'b1;
		end
	end

endmodule

`default_nettype wire

/* vx_mem_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module vx_mem_controller import vx_pkg::*; (
	input  logic            clk,
	input  imem_wr_t        imem_wr,
	input  logic [xlen-1:0] imem_addr,
	output instr_u          imem_data,
	input  dmem_req_t       dmem_req,
	output logic [xlen-1:0] dmem_rdata
);

	instr_u             imem [imem_words];
	logic [xlen-1:0]    dmem [dmem_words];
	logic [imem_aw-1:0] imem_idx;
	logic [dmem_aw-1:0] dmem_idx;
	logic               dmem_rd_en;
	logic               dmem_wr_en;

	// Byte addresses in, word index out; upper bits wrap
	assign imem_idx = imem_addr[2 +: imem_aw];
	assign dmem_idx = dmem_req.addr[2 +: dmem_aw];

	assign dmem_wr_en = dmem_req.valid && dmem_req.write;
	assign dmem_rd_en = dmem_req.valid && !dmem_req.write;

	// Program load port
	always_ff @(posedge clk) begin
		if (imem_wr.en) begin
			imem[imem_wr.addr] <= imem_wr.data;
		end
	end

	always_ff @(posedge clk) begin
		imem_data <= imem[imem_idx];
	end

	always_ff @(posedge clk) begin
		if (dmem_wr_en) begin
			dmem[dmem_idx] <= dmem_req.wdata;
		end
	end

	// Read data holds until the next load
	always_ff @(posedge clk) begin
		if (dmem_rd_en) begin
			dmem_rdata <= dmem[dmem_idx];
		end
	end

endmodule

`default_nettype wire

/* vx_pkg.sv */
`default_nettype none

package vx_pkg;

	localparam int xlen = 32;
	localparam int nregs = 16;
	localparam int imem_words = 64;
	localparam int dmem_words = 256;
	localparam int imem_aw = $clog2(imem_words);
	localparam int dmem_aw = $clog2(dmem_words);

	// Stores to this byte address go out on the IO bus
	localparam logic [xlen-1:0] io_bus_addr = 32'h0000_1000;

	// Opcode field in bits 31:28
	localparam logic [3:0] op_nop    = 4'h0;
	localparam logic [3:0] op_add    = 4'h1;
	localparam logic [3:0] op_sub    = 4'h2;
	localparam logic [3:0] op_and    = 4'h3;
	localparam logic [3:0] op_or     = 4'h4;
	localparam logic [3:0] op_xor    = 4'h5;
	localparam logic [3:0] op_addi   = 4'h6;
	localparam logic [3:0] op_lw     = 4'h7;
	localparam logic [3:0] op_sw     = 4'h8;
	localparam logic [3:0] op_beq    = 4'h9;
	localparam logic [3:0] op_bne    = 4'ha;
	localparam logic [3:0] op_jal    = 4'hb;
	localparam logic [3:0] op_ebreak = 4'hc;

	typedef struct packed {
		logic [3:0]  opcode;
		logic [3:0]  rd;
		logic [3:0]  rs1;
		logic [3:0]  rs2;
		logic [15:0] unused;
	} instr_r_t;

	// SW and branches read rd as their second source
	typedef struct packed {
		logic [3:0]         opcode;
		logic [3:0]         rd;
		logic [3:0]         rs1;
		logic signed [19:0] imm;
	} instr_i_t;

	typedef union packed {
		instr_r_t r;
		instr_i_t i;
	} instr_u;

	typedef struct packed {
		logic            valid;
		logic [xlen-1:0] pc;
		instr_u          instr;
	} fetch_t;

	typedef struct packed {
		logic            valid;
		logic [xlen-1:0] pc;
		instr_u          instr;
		logic [3:0]      rs1;
		logic [3:0]      rs2;
	} issue_t;

	typedef struct packed {
		logic            valid;
		logic [xlen-1:0] target;
	} redirect_t;

	typedef struct packed {
		logic            valid;
		logic [3:0]      rd;
		logic [xlen-1:0] data;
	} wb_t;

	typedef struct packed {
		logic            valid;
		logic            write;
		logic [xlen-1:0] addr;
		logic [xlen-1:0] wdata;
	} dmem_req_t;

	typedef struct packed {
		logic               en;
		logic [imem_aw-1:0] addr;
		logic [xlen-1:0]    data;
	} imem_wr_t;

	function automatic logic writes_rd(input logic [3:0] op);
		return op inside {op_add, op_sub, op_and, op_or, op_xor, op_addi, op_lw, op_jal};
	endfunction

endpackage

`default_nettype wire

/* vx_scheduler.sv */
`timescale 1ns/1ps
`default_nettype none

module vx_scheduler import vx_pkg::*; (
	input  logic   clk,
	input  logic   rst_n,
	input  fetch_t fetch,
	input  redirect_t redirect,
	input  wb_t    wb,
	output issue_t issue,
	output logic   schedule_delay
);

	logic             held_valid;
	logic [xlen-1:0]  held_pc;
	instr_u           held_instr;
	logic [nregs-1:0] pending;
	logic [nregs-1:0] set_mask;
	logic [nregs-1:0] clr_mask;
	logic [3:0]       op;
	logic [3:0]       src1;
	logic [3:0]       src2;
	logic [3:0]       dst;
	logic             dst_en;
	logic             hazard;
	logic             last_valid;
	logic [3:0]       last_rd;

	// Source decode with r0 standing for no operand
	always_comb begin
		op   = held_instr.r.opcode;
		src1 = '0;
		src2 = '0;
		case (op)
			op_add, op_sub, op_and, op_or, op_xor: begin
				src1 = held_instr.r.rs1;
				src2 = held_instr.r.rs2;
			end
			op_addi, op_lw: src1 = held_instr.i.rs1;
			op_sw, op_beq, op_bne: begin
				src1 = held_instr.i.rs1;
				src2 = held_instr.i.rd;
			end
			default: ;
		endcase
	end

	assign dst    = held_instr.i.rd;
	assign dst_en = writes_rd(op);
	assign hazard = pending[src1] || pending[src2] || (dst_en && pending[dst]);

	assign schedule_delay = held_valid && hazard;

	always_comb begin
		issue.valid = held_valid && !hazard && !redirect.valid;
		issue.pc    = held_pc;
		issue.instr = held_instr;
		issue.rs1   = src1;
		issue.rs2   = src2;
	end

	always_ff @(posedge clk) begin
		if (!schedule_delay) begin
			held_pc    <= fetch.pc;
			held_instr <= fetch.instr;
		end
		if (!rst_n) begin
			held_valid <= 1'b0;
		end else if (redirect.valid) begin
			held_valid <= 1'b0;
		end else if (!schedule_delay) begin
			held_valid <= fetch.valid;
		end
	end

	// The instruction issued just before a redirect is squashed in execute
	always_comb begin
		set_mask = '0;
		clr_mask = '0;
		if (issue.valid && dst_en && dst != '0) begin
			set_mask[dst] = 1'b1;
		end
		if (wb.valid) begin
			clr_mask[wb.rd] = 1'b1;
		end
		if (redirect.valid && last_valid) begin
			clr_mask[last_rd] = 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		last_rd <= dst;
		if (!rst_n) begin
			pending    <= '0;
			last_valid <= 1'b0;
		end else begin
			pending    <= (pending | set_mask) & ~clr_mask;
			last_valid <= issue.valid && dst_en;
		end
	end

endmodule

`default_nettype wire
